// ==== compile.f ====
hw/memPkg.sv
hw/byteRam.sv
hw/storeSerializer.sv
hw/byteAssembler.sv
hw/memControl.sv
hw/memSubsystem.sv
sim/memSubsystemTb.sv

// ==== sim/memSubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
    import memPkg::*;

    localparam int initOps = 65;
    localparam int directedOps = 16;
    localparam int randomOps = 150;
    localparam int pairOps = 16;
    localparam int stallOps = 24;
    // random ops and pairs may each take two accesses
    localparam int numOps = initOps + directedOps + 2 * randomOps + 2 * pairOps + stallOps;
    localparam int timeoutLimit = numOps * 8 + 200;

    logic clk = 1'b0;
    logic rst;
    logic stall;
    fetchReqT fetchReq;
    dataReqT dataReq;
    respT fetchResp;
    respT dataResp;

    byteT refMem [65536];
    logic [31:0] lfsrState = 32'h1a4137da;
    int cycleCount = 0;
    int errorCount = 0;
    int checkCount = 0;

    // what the monitor expects from each port
    logic fetchPending;
    addrT fetchAddrExp;
    int fetchStart;
    int fetchLatExp;
    int fetchStalls;
    logic dataPending;
    logic dataIsStore;
    addrT dataAddrExp;
    int dataLenExp;
    wordT dataWordExp;
    int dataStart;
    int dataLatExp;
    int dataStalls;

    memSubsystem #(
        .ramAddrBits (16)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .fetchReq  (fetchReq),
        .dataReq   (dataReq),
        .fetchResp (fetchResp),
        .dataResp  (dataResp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        while (cycleCount < timeoutLimit) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles, a request never finished", cycleCount);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic int randomLen();
        logic [1:0] r;
        r = 2'(randomBits(2));
        return (r == 2'd0) ? 1 : (r == 2'd1) ? 2 : 4;
    endfunction

    // little-endian, upper bytes zero
    function automatic wordT expectedWord(input addrT addr, input int len);
        wordT w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[i*8 +: 8] = refMem[addr[15:0] + 16'(i)];
        end
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic reportError(input string what);
        errorCount++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (stall) begin
                if (fetchResp.done === 1'b1 || dataResp.done === 1'b1) begin
                    reportError("done was high while stall was high");
                end
                if (fetchPending) fetchStalls++;
                if (dataPending) dataStalls++;
            end
            if (dataResp.done === 1'b1) begin
                if (!dataPending) begin
                    reportError("data done came with no data request pending");
                end else begin
                    checkValue("data latency", cycleCount - dataStart, dataLatExp + dataStalls);
                    if (dataIsStore) begin
                        for (int i = 0; i < dataLenExp; i++) begin
                            refMem[dataAddrExp[15:0] + 16'(i)] = dataWordExp[i*8 +: 8];
                        end
                    end else begin
                        checkValue("dataResp.data", dataResp.data,
                                   expectedWord(dataAddrExp, dataLenExp));
                    end
                    dataPending = 1'b0;
                end
            end
            if (fetchResp.done === 1'b1) begin
                if (!fetchPending) begin
                    reportError("fetch done came with no fetch request pending");
                end else begin
                    checkValue("fetch latency", cycleCount - fetchStart, fetchLatExp + fetchStalls);
                    checkValue("fetchResp.data", fetchResp.data, expectedWord(fetchAddrExp, 4));
                    fetchPending = 1'b0;
                end
            end
        end
    end

    task automatic startFetch(input addrT addr, input int queueCycles);
        fetchReq.en = 1'b1;
        fetchReq.addr = addr;
        fetchAddrExp = addr;
        fetchStart = cycleCount;
        fetchLatExp = 5 + queueCycles;
        fetchStalls = 0;
        fetchPending = 1'b1;
    endtask

    task automatic startData(input logic isStore, input int len, input addrT addr,
                             input wordT data);
        dataReq.en = 1'b1;
        dataReq.isStore = isStore;
        dataReq.len = accessLenE'(len[2:0]);
        dataReq.addr = addr;
        dataReq.data = data;
        dataIsStore = isStore;
        dataAddrExp = addr;
        dataLenExp = len;
        dataWordExp = data;
        dataStart = cycleCount;
        dataLatExp = isStore ? len : len + 1;
        dataStalls = 0;
        dataPending = 1'b1;
    endtask

    // en drops in the cycle after done
    task automatic finishFetch();
        wait (!fetchPending);
        @(posedge clk);
        #2;
        fetchReq.en = 1'b0;
    endtask

    task automatic finishData();
        wait (!dataPending);
        @(posedge clk);
        #2;
        dataReq.en = 1'b0;
    endtask

    task automatic doFetch(input addrT addr);
        @(posedge clk);
        #2;
        startFetch(addr, 0);
        finishFetch();
    endtask

    task automatic doData(input logic isStore, input int len, input addrT addr, input wordT data);
        @(posedge clk);
        #2;
        startData(isStore, len, addr, data);
        finishData();
    endtask

    // fetch waits for the whole data access plus one idle cycle
    task automatic doPair(input logic isStore, input int len, input addrT dataAddr,
                          input wordT data, input addrT instAddr);
        @(posedge clk);
        #2;
        startData(isStore, len, dataAddr, data);
        startFetch(instAddr, (isStore ? len : len + 1) + 1);
        fork
            finishData();
            finishFetch();
        join
    endtask

    task automatic doStalledRead(input logic isFetch, input int len, input addrT addr,
                                 input int delay, input int stallLen);
        @(posedge clk);
        #2;
        if (isFetch) startFetch(addr, 0);
        else startData(1'b0, len, addr, '0);
        repeat (delay) @(posedge clk);
        #2;
        stall = 1'b1;
        repeat (stallLen) @(posedge clk);
        #2;
        stall = 1'b0;
        if (isFetch) finishFetch();
        else finishData();
    endtask

    initial begin
        addrT addr;
        addrT instAddr;
        wordT data;
        int len;
        int delay;
        int stallLen;
        logic [1:0] kind;
        logic pick;
        rst = 1'b1;
        stall = 1'b0;
        fetchReq = '0;
        dataReq = '0;
        fetchPending = 1'b0;
        dataPending = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (8) begin
            @(negedge clk);
            checkValue("fetchResp.done", 32'(fetchResp.done), 0);
            checkValue("dataResp.done", 32'(dataResp.done), 0);
        end
        // known contents for the whole window
        for (int a = 0; a < initOps * 4; a += 4) begin
            doData(1'b1, 4, addrT'(a), randomBits(32));
        end
        for (int i = 0; i < directedOps / 4; i++) begin
            addr = randomBits(8);
            doFetch(addr);
            doData(1'b0, 1, addr, '0);
            doData(1'b0, 2, addr, '0);
            doData(1'b0, 4, addr, '0);
        end
        for (int i = 0; i < randomOps; i++) begin
            kind = 2'(randomBits(2));
            addr = randomBits(8);
            len = randomLen();
            if (kind == 2'd0) begin
                doFetch(addr);
            end else if (kind == 2'd1) begin
                doData(1'b0, len, addr, '0);
            end else begin
                doData(1'b1, len, addr, randomBits(32));
                // bytes past a short store must be untouched
                doData(1'b0, 4, addr, '0);
            end
        end
        for (int i = 0; i < pairOps; i++) begin
            pick = 1'(randomBits(1));
            len = randomLen();
            addr = randomBits(8);
            data = randomBits(32);
            instAddr = randomBits(8);
            doPair(pick, len, addr, data, instAddr);
        end
        for (int i = 0; i < stallOps; i++) begin
            pick = 1'(randomBits(1));
            addr = randomBits(8);
            len = pick ? 4 : randomLen();
            // stall may start as late as the cycle the done is due
            delay = 1 + int'(randomBits(3)) % (len + 1);
            stallLen = 1 + int'(randomBits(2));
            doStalledRead(pick, len, addr, delay, stallLen);
        end
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
    parameter int ramAddrBits = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  memPkg::fetchReqT fetchReq,
    input  memPkg::dataReqT  dataReq,
    output memPkg::respT     fetchResp,
    output memPkg::respT     dataResp
);
    import memPkg::*;

    ramBusT ramReq;
    byteT rdata;
    byteT storeByte;
    wordT assembled;
    accessLenE asmLen;
    logic capture;
    logic loadStore;
    logic [1:0] byteIdx;

    // matches the arbitration at acceptance, fetches are whole words
    assign asmLen = dataReq.en ? dataReq.len : lenWord;

    memControl ctrl (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .fetchReq  (fetchReq),
        .dataReq   (dataReq),
        .assembled (assembled),
        .storeByte (storeByte),
        .ramReq    (ramReq),
        .capture   (capture),
        .loadStore (loadStore),
        .byteIdx   (byteIdx),
        .fetchResp (fetchResp),
        .dataResp  (dataResp)
    );

    byteAssembler assembler (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .capture (capture),
        .clear   (loadStore),
        .byteIdx (byteIdx),
        .len     (asmLen),
        .rdata   (rdata),
        .word    (assembled)
    );

    storeSerializer serializer (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .load    (loadStore),
        .wordIn  (dataReq.data),
        .byteIdx (byteIdx),
        .byteOut (storeByte)
    );

    byteRam #(
        .ramAddrBits (ramAddrBits)
    ) ram (
        .clk    (clk),
        .stall  (stall),
        .ramReq (ramReq),
        .rdata  (rdata)
    );

endmodule

`default_nettype wire

// ==== hw/memControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module memControl (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  memPkg::fetchReqT fetchReq,
    input  memPkg::dataReqT  dataReq,
    input  memPkg::wordT     assembled,
    input  memPkg::byteT     storeByte,
    output memPkg::ramBusT   ramReq,
    output logic             capture,
    output logic             loadStore,
    output logic [1:0]       byteIdx,
    output memPkg::respT     fetchResp,
    output memPkg::respT     dataResp
);
    import memPkg::*;

    ctrlStateE state;
    accessLenE lenQ;
    addrT addrQ;
    logic [2:0] stage;
    logic isRead;
    logic last;
    logic accept;

    assign isRead = (state == readInst) || (state == readData);
    assign accept = (state == idle) && (dataReq.en || fetchReq.en);

    // reads run one stage past the length to catch the last returning byte
    always_comb begin
        case (state)
            readInst, readData: last = (stage == lenQ);
            writeData: last = (stage == 3'(lenQ - 3'd1));
            default: last = 1'b0;
        endcase
    end

    assign ramReq.we = (state == writeData);
    assign ramReq.addr = addrQ + addrT'(stage);
    assign ramReq.wdata = storeByte;

    // rdata lags the address by one stage
    assign capture = isRead && (stage != 3'd0);
    assign byteIdx = (state == writeData) ? stage[1:0] : stage[1:0] - 2'd1;
    assign loadStore = accept;

    assign fetchResp.done = (state == readInst) && last && !stall;
    assign fetchResp.data = assembled;
    assign dataResp.done = ((state == readData) || (state == writeData)) && last && !stall;
    assign dataResp.data = assembled;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            stage <= 3'd0;
            lenQ <= lenWord;
        end else if (!stall) begin
            case (state)
                idle: begin
                    stage <= 3'd0;
                    // data port wins
                    if (dataReq.en) begin
                        state <= dataReq.isStore ? writeData : readData;
                        lenQ <= dataReq.len;
                    end else if (fetchReq.en) begin
                        state <= readInst;
                        lenQ <= lenWord;
                    end
                end
                default: begin
                    if (last) begin
                        state <= idle;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && accept) begin
            addrQ <= dataReq.en ? dataReq.addr : fetchReq.addr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/byteAssembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteAssembler (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              capture,
    input  logic              clear,
    input  logic [1:0]        byteIdx,
    input  memPkg::accessLenE len,
    input  memPkg::byteT      rdata,
    output memPkg::wordT      word
);
    import memPkg::*;

    accessLenE lenQ;
    wordT wordQ;

    // length is latched together with the clear
    always_ff @(posedge clk) begin
        if (rst) begin
            lenQ <= lenWord;
        end else if (!stall && clear) begin
            lenQ <= len;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (clear) begin
                wordQ <= '0;
            end else if (capture) begin
                wordQ[byteIdx*8 +: 8] <= rdata;
            end
        end
    end

    // final byte goes straight through so the word is ready with done
    always_comb begin
        word = wordQ;
        if (capture) begin
            word[byteIdx*8 +: 8] = rdata;
        end
        for (int i = 0; i < 4; i++) begin
            if (i >= lenQ) begin
                word[i*8 +: 8] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/storeSerializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module storeSerializer (
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  logic         load,
    input  memPkg::wordT wordIn,
    input  logic [1:0]   byteIdx,
    output memPkg::byteT byteOut
);
    logic [31:0] wordQ;

    // requester may change its data after done
    always_ff @(posedge clk) begin
        if (rst) begin
            wordQ <= '0;
        end else if (!stall && load) begin
            wordQ <= wordIn;
        end
    end

    // little-endian lane select
    assign byteOut = wordQ[byteIdx*8 +: 8];

endmodule

`default_nettype wire

// ==== hw/byteRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteRam #(
    parameter int ramAddrBits = 16
) (
    input  logic           clk,
    input  logic           stall,
    input  memPkg::ramBusT ramReq,
    output memPkg::byteT   rdata
);
    localparam int depth = 2 ** ramAddrBits;

    logic [7:0] mem [depth];
    logic [ramAddrBits-1:0] ramAddr;

    // upper address bits wrap
    assign ramAddr = ramReq.addr[ramAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (ramReq.we) begin
                mem[ramAddr] <= ramReq.wdata;
            end
            rdata <= mem[ramAddr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/memPkg.sv ====
`default_nettype none

package memPkg;

    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    typedef logic [7:0] byteT;

    // value equals the byte count
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLenE;

    typedef enum logic [1:0] {
        idle,
        readInst,
        readData,
        writeData
    } ctrlStateE;

    typedef struct packed {
        logic en;
        addrT addr;
    } fetchReqT;

    typedef struct packed {
        logic en;
        logic isStore;
        accessLenE len;
        addrT addr;
        wordT data;
    } dataReqT;

    // shared by fetch and data responses
    typedef struct packed {
        logic done;
        wordT data;
    } respT;

    // request side toward the RAM
    typedef struct packed {
        logic we;
        addrT addr;
        byteT wdata;
    } ramBusT;

endpackage

`default_nettype wire
